/* design/cache_pkg.sv */
// geometry is fixed at 16 sets x 4 ways x one 32-bit word; every rtl lookup relies on these widths
package cache_pkg;

	//////////////////////////////////////////////////
	// geometry
	//////////////////////////////////////////////////
	localparam int NUM_WAYS    = 4;
	localparam int WAY_BITS    = 2;
	localparam int SET_BITS    = 4;
	localparam int NUM_SETS    = 16;
	localparam int OFFSET_BITS = 2;		// byte within the word
	localparam int TAG_BITS    = 26;
	localparam int WORD_BITS   = 32;

	typedef enum logic [3:0] {
		OP_READ       = 4'd0,	// l1 data read
		OP_WRITE      = 4'd1,	// l1 data write
		OP_IFETCH     = 4'd2,	// instruction fetch, read-like
		OP_INVALIDATE = 4'd3,	// invalidate from l2
		OP_SNOOP      = 4'd4,	// data request from l2
		OP_CLEAR      = 4'd8	// all lines to invalid
	} cache_op_e;

	typedef enum logic [1:0] {
		INVALID   = 2'd0,
		SHARED    = 2'd1,
		EXCLUSIVE = 2'd2,
		MODIFIED  = 2'd3
	} mesi_e;

	//////////////////////////////////////////////////
	// address, seen as a raw word or as its fields
	//////////////////////////////////////////////////
	typedef struct packed {
		logic [TAG_BITS-1:0]    tag;	// upper bits
		logic [SET_BITS-1:0]    set;
		logic [OFFSET_BITS-1:0] offset;	// ignored, one word per line
	} addr_fields_t;

	typedef union packed {
		logic [WORD_BITS-1:0] raw;
		addr_fields_t         f;
	} addr_u;

	typedef struct packed {
		cache_op_e            op;
		addr_u                addr;
		logic [WORD_BITS-1:0] wdata;	// store data for a write
		logic [WORD_BITS-1:0] fill_data;	// memory word for a read miss
		logic                 other_hit;	// another cache holds the line
	} cache_cmd_t;

	typedef struct packed {
		logic                 hit;
		logic [WAY_BITS-1:0]  way;	// hit way or victim
		mesi_e                prior_state;	// invalid on a miss
		logic [WORD_BITS-1:0] data;
	} cache_rsp_t;

	typedef struct packed {
		logic                en;
		logic                clear_all;
		logic [SET_BITS-1:0] set;
		logic [WAY_BITS-1:0] way;
		logic [TAG_BITS-1:0] tag;
		mesi_e               state;
	} tag_wr_t;

	typedef struct packed {
		logic                 en;
		logic [SET_BITS-1:0]  set;
		logic [WAY_BITS-1:0]  way;
		logic [WORD_BITS-1:0] data;
	} data_wr_t;

endpackage

/* design/cache_top.sv */
// one command per cycle, no back-pressure; the consumer must take every response a cycle later
module cache_top
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	input  logic       cmd_valid,
	input  cache_cmd_t cmd,
	output logic       rsp_valid,
	output cache_rsp_t rsp
);

	logic [NUM_WAYS-1:0]  match_ways;	// tag equal and line valid
	logic [NUM_WAYS-1:0]  valid_ways;	// line not invalid
	mesi_e [NUM_WAYS-1:0] set_states;	// states of the selected set
	logic                 hit;
	logic [WAY_BITS-1:0]  way;
	mesi_e                prior_state;
	logic [WORD_BITS-1:0] rdata;
	tag_wr_t              tag_wr;
	data_wr_t             data_wr;
	logic                 alloc;	// a miss fills a line

	//////////////////////////////////////////////////
	// lookup path
	//////////////////////////////////////////////////
	tag_array tag_array_i (
		.clk        (clk),
		.reset_n    (reset_n),
		.set        (cmd.addr.f.set),
		.tag        (cmd.addr.f.tag),
		.tag_wr     (tag_wr),
		.match_ways (match_ways),
		.valid_ways (valid_ways),
		.set_states (set_states)
	);

	way_select way_select_i (
		.clk         (clk),
		.reset_n     (reset_n),
		.match_ways  (match_ways),
		.valid_ways  (valid_ways),
		.set_states  (set_states),
		.alloc       (alloc),
		.hit         (hit),
		.way         (way),
		.prior_state (prior_state)
	);

	data_array data_array_i (
		.clk     (clk),
		.reset_n (reset_n),
		.set     (cmd.addr.f.set),
		.way     (way),
		.data_wr (data_wr),
		.rdata   (rdata)
	);

	//////////////////////////////////////////////////
	// write path and response
	//////////////////////////////////////////////////
	line_update line_update_i (
		.clk         (clk),
		.reset_n     (reset_n),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.hit         (hit),
		.way         (way),
		.prior_state (prior_state),
		.rdata       (rdata),
		.tag_wr      (tag_wr),
		.data_wr     (data_wr),
		.alloc       (alloc),
		.rsp_valid   (rsp_valid),
		.rsp         (rsp)
	);

endmodule

/* design/data_array.sv */
// one word per line, written at the accept edge; the read mux follows set and way combinationally
module data_array
	import cache_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic [SET_BITS-1:0]  set,
	input  logic [WAY_BITS-1:0]  way,
	input  data_wr_t             data_wr,
	output logic [WORD_BITS-1:0] rdata
);

	logic [WORD_BITS-1:0] data_mem [NUM_SETS][NUM_WAYS];	// indexed set then way

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				for (int w = 0; w < NUM_WAYS; w++) begin
					data_mem[s][w] <= '0;
				end
			end
		end else if (data_wr.en) begin
			data_mem[data_wr.set][data_wr.way] <= data_wr.data;	// single line per command
		end
	end

	// way mux of the selected set
	always_comb begin
		case (way)
			2'd0:    rdata = data_mem[set][0];
			2'd1:    rdata = data_mem[set][1];
			2'd2:    rdata = data_mem[set][2];
			default: rdata = data_mem[set][3];
		endcase
	end

endmodule

/* design/line_update.sv */
// applies the MESI table at the accept edge; the response is registered, one cycle of latency
module line_update
	import cache_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 cmd_valid,
	input  cache_cmd_t           cmd,
	input  logic                 hit,
	input  logic [WAY_BITS-1:0]  way,
	input  mesi_e                prior_state,
	input  logic [WORD_BITS-1:0] rdata,
	output tag_wr_t              tag_wr,
	output data_wr_t             data_wr,
	output logic                 alloc,
	output logic                 rsp_valid,
	output cache_rsp_t           rsp
);

	logic [WORD_BITS-1:0] rsp_data;	// data field of the next response

	//////////////////////////////////////////////////
	// next state and array writes
	//////////////////////////////////////////////////
	always_comb begin
		tag_wr           = '0;
		tag_wr.set       = cmd.addr.f.set;
		tag_wr.way       = way;
		tag_wr.tag       = cmd.addr.raw[WORD_BITS-1 -: TAG_BITS];	// top bits of the address
		tag_wr.state     = INVALID;
		data_wr          = '0;
		data_wr.set      = cmd.addr.f.set;
		data_wr.way      = way;
		alloc            = 1'b0;
		rsp_data         = '0;
		if (cmd_valid) begin
			case (cmd.op)
				OP_READ, OP_IFETCH: begin
					if (hit) begin
						rsp_data = rdata;	// state holds on a read hit
					end else begin
						tag_wr.en    = 1'b1;
						tag_wr.state = cmd.other_hit ? SHARED : EXCLUSIVE;
						data_wr.en   = 1'b1;
						data_wr.data = cmd.fill_data;
						alloc        = 1'b1;
						rsp_data     = cmd.fill_data;
					end
				end
				OP_WRITE: begin
					tag_wr.en    = 1'b1;	// any state goes to modified
					tag_wr.state = MODIFIED;
					data_wr.en   = 1'b1;
					data_wr.data = cmd.wdata;
					alloc        = !hit;	// write miss allocates
					rsp_data     = cmd.wdata;
				end
				OP_INVALIDATE: begin
					tag_wr.en = hit;	// miss changes nothing
				end
				OP_SNOOP: begin
					tag_wr.en    = hit;
					tag_wr.state = SHARED;
					rsp_data     = hit ? rdata : '0;
				end
				OP_CLEAR: begin
					tag_wr.clear_all = 1'b1;
				end
				default: ;	// unknown codes are a no-op
			endcase
		end
	end

	//////////////////////////////////////////////////
	// response register
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= cmd_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			rsp.hit         <= hit;
			rsp.way         <= way;
			rsp.prior_state <= prior_state;
			rsp.data        <= rsp_data;
		end
	end

	// each accepted command gets its response on the next cycle
	assert property (@(posedge clk) disable iff (!reset_n) cmd_valid |=> rsp_valid)
		else $error("response missing one cycle after an accepted command");

endmodule

/* design/tag_array.sv */
// writes land at the accept edge, reads are combinational; clear_all beats any per-line write
module tag_array
	import cache_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic [SET_BITS-1:0]  set,
	input  logic [TAG_BITS-1:0]  tag,
	input  tag_wr_t              tag_wr,
	output logic [NUM_WAYS-1:0]  match_ways,
	output logic [NUM_WAYS-1:0]  valid_ways,
	output mesi_e [NUM_WAYS-1:0] set_states
);

	logic [TAG_BITS-1:0] tag_mem [NUM_SETS][NUM_WAYS];	// meaningless while state is invalid
	mesi_e               state_mem [NUM_SETS][NUM_WAYS];

	//////////////////////////////////////////////////
	// tag storage
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (tag_wr.en && !tag_wr.clear_all) begin
			tag_mem[tag_wr.set][tag_wr.way] <= tag_wr.tag;
		end
	end

	// state storage, cleared by reset or clear
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				for (int w = 0; w < NUM_WAYS; w++) begin
					state_mem[s][w] <= INVALID;
				end
			end
		end else if (tag_wr.clear_all) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				for (int w = 0; w < NUM_WAYS; w++) begin
					state_mem[s][w] <= INVALID;	// whole cache in one cycle
				end
			end
		end else if (tag_wr.en) begin
			state_mem[tag_wr.set][tag_wr.way] <= tag_wr.state;
		end
	end

	//////////////////////////////////////////////////
	// parallel compare of the selected set
	//////////////////////////////////////////////////
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			set_states[w] = state_mem[set][w];
			valid_ways[w] = (state_mem[set][w] != INVALID);
			match_ways[w] = valid_ways[w] && (tag_mem[set][w] == tag);	// hit in way w
		end
	end

	// a clear must not be mixed with a line fill from the update logic
	assert property (@(posedge clk) disable iff (!reset_n)
		tag_wr.clear_all |-> !(tag_wr.en && tag_wr.state != INVALID))
		else $error("clear_all together with a non-invalid line write");

endmodule

/* design/way_select.sv */
// combinational select; round-robin victim only when all four ways of the set are valid
module way_select
	import cache_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic [NUM_WAYS-1:0]  match_ways,
	input  logic [NUM_WAYS-1:0]  valid_ways,
	input  mesi_e [NUM_WAYS-1:0] set_states,
	input  logic                 alloc,
	output logic                 hit,
	output logic [WAY_BITS-1:0]  way,
	output mesi_e                prior_state
);

	logic [WAY_BITS-1:0] rr_cnt;	// global replacement pointer
	logic [WAY_BITS-1:0] hit_way;
	logic [WAY_BITS-1:0] victim;
	logic                set_full;

	//////////////////////////////////////////////////
	// hit encoder
	//////////////////////////////////////////////////
	always_comb begin
		case (match_ways)
			4'b0001: hit_way = 2'd0;
			4'b0010: hit_way = 2'd1;
			4'b0100: hit_way = 2'd2;
			4'b1000: hit_way = 2'd3;
			default: hit_way = 2'd0;	// miss
		endcase
	end

	// victim, lowest invalid way first
	always_comb begin
		victim = rr_cnt;	// used when the set is full
		for (int i = NUM_WAYS - 1; i >= 0; i--) begin
			if (!valid_ways[i]) begin
				victim = WAY_BITS'(i);
			end
		end
	end

	assign set_full    = &valid_ways;
	assign hit         = |match_ways;
	assign way         = hit ? hit_way : victim;
	assign prior_state = hit ? set_states[hit_way] : INVALID;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rr_cnt <= '0;
		end else if (alloc && set_full) begin
			rr_cnt <= rr_cnt + 1'b1;	// wraps after way 3
		end
	end

	// a tag may live in only one way of a set
	assert property (@(posedge clk) disable iff (!reset_n) $onehot0(match_ways))
		else $error("tag matches in more than one way");

endmodule

/* src.f */
design/cache_pkg.sv
design/tag_array.sv
design/way_select.sv
design/data_array.sv
design/line_update.sv
design/cache_top.sv
test/tb_clock.sv
test/tb_cache.sv

/* test/tb_cache.sv */
// the model assumes in-order commands, one per cycle; each response is due one cycle later
module tb_cache
	import cache_pkg::*;
();

	localparam int RAND_CMDS   = 32;
	localparam int NUM_CMDS    = 36 + RAND_CMDS;	// directed plus random commands
	localparam int CYCLE_LIMIT = NUM_CMDS + 20;

	logic       clk;
	logic       reset_n;
	logic       cmd_valid;
	cache_cmd_t cmd;
	logic       rsp_valid;
	cache_rsp_t rsp;

	cache_rsp_t exp_rsp;	// model answer, driven with the command
	cache_rsp_t exp_q;	// lines up with rsp
	int         test_id;
	int         id_q;
	logic       chk_q;	// a response is due this cycle
	int         errors;
	int         checked;
	int         cycles;
	string      test_names [7] = '{"reset_idle", "read_fill", "write_ifetch", "snoop_inval",
		"replacement", "clear_b2b", "random"};

	mesi_e                m_state [NUM_SETS][NUM_WAYS];	// model of the directory
	logic [TAG_BITS-1:0]  m_tag [NUM_SETS][NUM_WAYS];
	logic [WORD_BITS-1:0] m_data [NUM_SETS][NUM_WAYS];
	logic [WAY_BITS-1:0]  m_rr;	// global round-robin pointer
	logic [TAG_BITS-1:0]  tag_a, tag_b, tag_c, tag_d, tag_base;
	cache_op_e            rand_ops [7] = '{OP_READ, OP_WRITE, OP_IFETCH, OP_INVALIDATE, OP_SNOOP,
		OP_CLEAR, cache_op_e'(4'd9)};	// last one is an unsupported code

	tb_clock tb_clock_i (.clk(clk), .reset_n(reset_n));

	cache_top cache_top_i (
		.clk       (clk),
		.reset_n   (reset_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////
	task automatic fill_line(input int s, input int v, input bit full,
		input logic [TAG_BITS-1:0] tag, input mesi_e st, input logic [WORD_BITS-1:0] d);
		m_tag[s][v]   = tag;
		m_state[s][v] = st;
		m_data[s][v]  = d;
		if (full) m_rr = m_rr + 1'b1;	// pointer moves only on a full-set fill
	endtask

	task automatic model_step(input cache_cmd_t c, output cache_rsp_t r);
		int s;
		int hw;
		int v;
		bit h;
		bit full;
		s = c.addr.f.set;
		h = 1'b0;
		hw = 0;
		v = -1;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (m_state[s][w] != INVALID && m_tag[s][w] == c.addr.f.tag) begin
				h = 1'b1;
				hw = w;
			end
			if (v < 0 && m_state[s][w] == INVALID) v = w;	// lowest free way
		end
		full = (v < 0);
		if (full) v = m_rr;
		r.hit = h;
		r.way = h ? WAY_BITS'(hw) : WAY_BITS'(v);
		r.prior_state = h ? m_state[s][hw] : INVALID;
		r.data = '0;
		case (c.op)
			OP_READ, OP_IFETCH: begin
				if (h) r.data = m_data[s][hw];
				else begin
					fill_line(s, v, full, c.addr.f.tag, c.other_hit ? SHARED : EXCLUSIVE,
						c.fill_data);
					r.data = c.fill_data;
				end
			end
			OP_WRITE: begin
				if (h) begin
					m_state[s][hw] = MODIFIED;
					m_data[s][hw] = c.wdata;
				end else fill_line(s, v, full, c.addr.f.tag, MODIFIED, c.wdata);
				r.data = c.wdata;
			end
			OP_INVALIDATE: if (h) m_state[s][hw] = INVALID;
			OP_SNOOP: begin
				if (h) begin
					r.data = m_data[s][hw];	// owner hands the word to l2
					m_state[s][hw] = SHARED;
				end
			end
			OP_CLEAR: begin
				for (int i = 0; i < NUM_SETS; i++)
					for (int w = 0; w < NUM_WAYS; w++) m_state[i][w] = INVALID;
			end
			default: ;	// no-op
		endcase
	endtask

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////
	task automatic issue(input cache_op_e op, input logic [TAG_BITS-1:0] tag,
		input logic [SET_BITS-1:0] set, input logic other, input int id);
		cache_cmd_t c;
		cache_rsp_t r;
		@(posedge clk);
		c.op        = op;
		c.addr.raw  = {tag, set, 2'b00};
		c.wdata     = $urandom();
		c.fill_data = $urandom();
		c.other_hit = other;
		model_step(c, r);
		cmd_valid <= 1'b1;
		cmd       <= c;
		exp_rsp   <= r;
		test_id   <= id;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		cmd_valid <= 1'b0;
	endtask

	task automatic finish_run(input bit timed_out);
		$display("errors: %0d, responses checked: %0d, timeout: %0d", errors, checked, timed_out);
		if (errors == 0 && !timed_out) $display("Simulation PASSED");
		else $display("Simulation FAILED");
		$finish;
	endtask

	//////////////////////////////////////////////////
	// checking
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			chk_q   <= 1'b0;
			checked <= 0;
		end else begin
			chk_q   <= cmd_valid;
			exp_q   <= exp_rsp;
			id_q    <= test_id;
			checked <= checked + (chk_q ? 1 : 0);
		end
	end

	assert property (@(posedge clk) disable iff (!reset_n) chk_q |-> rsp == exp_q)
		else begin
			errors++;
			$write("FAIL %s: expected hit=%0b way=%0d state=%0d data=%h",
				test_names[$sampled(id_q)], $sampled(exp_q.hit), $sampled(exp_q.way),
				$sampled(exp_q.prior_state), $sampled(exp_q.data));
			$display(", actual hit=%0b way=%0d state=%0d data=%h", $sampled(rsp.hit),
				$sampled(rsp.way), $sampled(rsp.prior_state), $sampled(rsp.data));
		end
	assert property (@(posedge clk) disable iff (!reset_n) chk_q |-> rsp_valid)
		else begin
			errors++;
			$display("no response one cycle after a command");
		end
	assert property (@(posedge clk) disable iff (!reset_n) !chk_q |-> !rsp_valid)
		else begin
			errors++;
			$display("response appeared without a command");
		end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped by timeout after %0d cycles", cycles);
			finish_run(1'b1);
		end
	end

	//////////////////////////////////////////////////
	// directed and random commands
	//////////////////////////////////////////////////
	initial begin
		errors = 0;
		cycles = 0;
		void'($urandom(67532));
		cmd_valid <= 1'b0;
		cmd       <= '0;
		exp_rsp   <= '0;
		test_id   <= 0;
		for (int s = 0; s < NUM_SETS; s++)
			for (int w = 0; w < NUM_WAYS; w++) m_state[s][w] = INVALID;
		m_rr = '0;
		tag_a = TAG_BITS'($urandom());
		tag_b = TAG_BITS'($urandom());
		tag_c = TAG_BITS'($urandom());
		tag_d = TAG_BITS'($urandom());
		tag_base = TAG_BITS'($urandom());
		@(posedge reset_n);
		repeat (3) @(posedge clk);	// rsp_valid must stay low here
		issue(OP_READ, tag_a, 4'd1, 1'b0, 1);	// miss, exclusive fill
		issue(OP_READ, tag_a, 4'd1, 1'b0, 1);
		issue(OP_READ, tag_b, 4'd2, 1'b1, 1);	// other cache holds it, shared
		issue(OP_READ, tag_b, 4'd2, 1'b0, 1);
		issue(OP_WRITE, tag_a, 4'd1, 1'b0, 2);	// exclusive to modified
		issue(OP_WRITE, tag_b, 4'd2, 1'b0, 2);	// shared to modified
		issue(OP_WRITE, tag_c, 4'd3, 1'b0, 2);	// write miss allocates
		issue(OP_IFETCH, tag_a, 4'd1, 1'b0, 2);
		issue(OP_IFETCH, tag_a, 4'd1, 1'b0, 2);	// still modified
		issue(OP_WRITE, tag_a, 4'd1, 1'b0, 2);	// modified stays modified
		issue(OP_READ, tag_b, 4'd2, 1'b0, 2);
		issue(OP_READ, tag_d, 4'd4, 1'b0, 3);
		issue(OP_SNOOP, tag_d, 4'd4, 1'b0, 3);	// exclusive gives up the word
		issue(OP_READ, tag_d, 4'd4, 1'b0, 3);
		issue(OP_SNOOP, tag_a, 4'd1, 1'b0, 3);	// modified gives up the word
		issue(OP_READ, tag_a, 4'd1, 1'b0, 3);
		issue(OP_INVALIDATE, tag_a, 4'd1, 1'b0, 3);
		issue(OP_READ, tag_a, 4'd1, 1'b0, 3);	// must miss now
		for (int i = 0; i < 8; i++)
			issue(OP_READ, tag_base + TAG_BITS'(i), 4'd5, 1'b0, 4);	// ways 0-3, then round-robin
		for (int i = 0; i < 4; i++)
			issue(OP_READ, tag_base + TAG_BITS'(i), 4'd5, 1'b0, 4);	// evicted tags miss
		issue(OP_CLEAR, tag_a, 4'd1, 1'b0, 5);
		issue(OP_READ, tag_a, 4'd1, 1'b0, 5);
		issue(OP_READ, tag_b, 4'd2, 1'b0, 5);
		issue(OP_READ, tag_c, 4'd3, 1'b0, 5);
		issue(OP_READ, tag_d, 4'd4, 1'b0, 5);
		issue(OP_READ, tag_base, 4'd5, 1'b0, 5);
		for (int i = 0; i < RAND_CMDS; i++)	// two sets, six tags, so sets fill and evict
			issue(rand_ops[$urandom % 7], tag_base + TAG_BITS'($urandom % 6),
				SET_BITS'(6 + $urandom % 2), 1'($urandom % 2), 6);
		idle_cycle();
		repeat (3) @(posedge clk);	// last response drains
		finish_run(1'b0);
	end

endmodule

/* test/tb_clock.sv */
// free-running clock of period 10; reset_n is low for the first two rising edges only
module tb_clock (
	output logic clk,
	output logic reset_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// period 10
	end

	initial begin
		reset_n = 1'b0;
		repeat (2) @(posedge clk);
		reset_n <= 1'b1;	// released after two cycles
	end

endmodule
